/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pipe_ctrl
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Passes only when the pass message shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* branch_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Resolves branches and jumps in X into the next-PC select, and flushes
// the decode stage whenever the fetch path is redirected.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module branch_unit (
  input  logic              rst,
  input  ctrl_pkg::instr_t  instr,
  input  logic              instr_valid,
  input  logic              br_eq,
  input  logic              br_lt,
  output ctrl_pkg::pc_sel_t pc_sel,
  output logic              flush
);

  ctrl_pkg::opcode_t opc;
  logic              taken;

  assign opc = ctrl_pkg::opcode_of(instr);

  always_comb begin
    taken = 1'b0;
    if (instr_valid && (opc == ctrl_pkg::OPC_BRANCH)) begin
      case (ctrl_pkg::funct3_of(instr))
        ctrl_pkg::FNC_BEQ:                    taken = br_eq;
        ctrl_pkg::FNC_BNE:                    taken = !br_eq;
        ctrl_pkg::FNC_BLT, ctrl_pkg::FNC_BLTU: taken = br_lt;   // br_un set by decoder
        ctrl_pkg::FNC_BGE, ctrl_pkg::FNC_BGEU: taken = !br_lt;
        default:                              taken = 1'b0;    // Reserved conditions
      endcase
    end
  end

  always_comb begin
    if (rst) begin
      pc_sel = ctrl_pkg::PC_RESET;
    end else if (instr_valid && (opc == ctrl_pkg::OPC_JAL)) begin
      pc_sel = ctrl_pkg::PC_JAL;
    end else if ((instr_valid && (opc == ctrl_pkg::OPC_JALR)) || taken) begin
      pc_sel = ctrl_pkg::PC_ALU;   // Target computed by the ALU
    end else begin
      pc_sel = ctrl_pkg::PC_SEQ;
    end
  end

  assign flush = (pc_sel == ctrl_pkg::PC_JAL) || (pc_sel == ctrl_pkg::PC_ALU);

  // Only a valid jump or branch outside reset may squash decode
  always_comb begin
    assert #0 (!flush || (instr_valid && !rst && (pc_sel != ctrl_pkg::PC_SEQ)))
      else $error("branch_unit: flush raised without a redirect");
  end

endmodule

/* ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types, opcode and funct3 constants, select encodings and stage
// control structs for the RV32I pipeline control path.
////////////////////////////////////////////////////////////////////////////
package ctrl_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  opcode_t;   // Instruction bits 6:2
  typedef logic [2:0]  funct3_t;

  // Major opcodes
  localparam opcode_t OPC_LOAD   = 5'b00000;
  localparam opcode_t OPC_ITYPE  = 5'b00100;
  localparam opcode_t OPC_AUIPC  = 5'b00101;
  localparam opcode_t OPC_STORE  = 5'b01000;
  localparam opcode_t OPC_RTYPE  = 5'b01100;
  localparam opcode_t OPC_LUI    = 5'b01101;
  localparam opcode_t OPC_BRANCH = 5'b11000;
  localparam opcode_t OPC_JALR   = 5'b11001;
  localparam opcode_t OPC_JAL    = 5'b11011;

  // ALU functions
  localparam funct3_t FNC_ADD_SUB = 3'b000;
  localparam funct3_t FNC_SLL     = 3'b001;
  localparam funct3_t FNC_SLT     = 3'b010;
  localparam funct3_t FNC_SLTU    = 3'b011;
  localparam funct3_t FNC_XOR     = 3'b100;
  localparam funct3_t FNC_SRL_SRA = 3'b101;
  localparam funct3_t FNC_OR      = 3'b110;
  localparam funct3_t FNC_AND     = 3'b111;

  // Branch conditions
  localparam funct3_t FNC_BEQ  = 3'b000;
  localparam funct3_t FNC_BNE  = 3'b001;
  localparam funct3_t FNC_BLT  = 3'b100;
  localparam funct3_t FNC_BGE  = 3'b101;
  localparam funct3_t FNC_BLTU = 3'b110;
  localparam funct3_t FNC_BGEU = 3'b111;

  // Load widths
  localparam funct3_t FNC_LB  = 3'b000;
  localparam funct3_t FNC_LH  = 3'b001;
  localparam funct3_t FNC_LW  = 3'b010;
  localparam funct3_t FNC_LBU = 3'b100;
  localparam funct3_t FNC_LHU = 3'b101;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  typedef enum logic [1:0] {A_RS1 = 2'd0, A_PC = 2'd1, A_ZERO = 2'd2} a_sel_t;
  typedef enum logic {B_RS2 = 1'b0, B_IMM = 1'b1} b_sel_t;
  typedef enum logic [1:0] {FWD_NONE = 2'd0, FWD_ALU = 2'd1, FWD_LOAD = 2'd2} fwd_sel_t;
  typedef enum logic [1:0] {PC_RESET = 2'd0, PC_JAL = 2'd1, PC_SEQ = 2'd2, PC_ALU = 2'd3} pc_sel_t;
  typedef enum logic [1:0] {WB_MEM = 2'd0, WB_ALU = 2'd1, WB_PC4 = 2'd2} wb_sel_t;

  typedef enum logic [2:0] {
    LDX_W  = 3'd0,
    LDX_HU = 3'd1,
    LDX_H  = 3'd2,
    LDX_BU = 3'd3,
    LDX_B  = 3'd4
  } ldx_t;

  typedef struct packed {
    alu_op_t  alu_op;
    a_sel_t   a_sel;
    b_sel_t   b_sel;
    logic     br_un;   // Unsigned branch compare
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
  } x_ctrl_t;

  typedef struct packed {
    logic     rf_we;
    wb_sel_t  wb_sel;
    ldx_t     ldx;
    reg_idx_t rd;
  } wf_ctrl_t;

  function automatic opcode_t opcode_of(instr_t instr);
    return instr[6:2];
  endfunction

  function automatic funct3_t funct3_of(instr_t instr);
    return instr[14:12];
  endfunction

  function automatic reg_idx_t rd_of(instr_t instr);
    return instr[11:7];
  endfunction

  function automatic reg_idx_t rs1_of(instr_t instr);
    return instr[19:15];
  endfunction

  function automatic reg_idx_t rs2_of(instr_t instr);
    return instr[24:20];
  endfunction

  // Opcodes that produce a register result
  function automatic logic writes_rd(opcode_t opc);
    return opc inside {OPC_RTYPE, OPC_ITYPE, OPC_LOAD, OPC_JAL, OPC_JALR, OPC_AUIPC, OPC_LUI};
  endfunction

endpackage

/* exec_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// X-stage decoder. Turns the instruction in X into the ALU operation,
// the operand selects and the unsigned-compare flag for the branch unit.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module exec_decoder (
  input  ctrl_pkg::instr_t  instr,
  input  logic              instr_valid,
  output ctrl_pkg::alu_op_t alu_op,
  output ctrl_pkg::a_sel_t  a_sel,
  output ctrl_pkg::b_sel_t  b_sel,
  output logic              br_un
);

  ctrl_pkg::opcode_t opc;
  ctrl_pkg::funct3_t f3;
  logic              alt;   // Bit 30 picks SUB and SRA

  assign opc = ctrl_pkg::opcode_of(instr);
  assign f3  = ctrl_pkg::funct3_of(instr);
  assign alt = instr[30];

  // Shared ALU table for register and immediate forms
  function automatic ctrl_pkg::alu_op_t alu_of(ctrl_pkg::funct3_t fn, logic alt_fn);
    ctrl_pkg::alu_op_t op;
    case (fn)
      ctrl_pkg::FNC_ADD_SUB: op = alt_fn ? ctrl_pkg::ALU_SUB : ctrl_pkg::ALU_ADD;
      ctrl_pkg::FNC_SLL:     op = ctrl_pkg::ALU_SLL;
      ctrl_pkg::FNC_SLT:     op = ctrl_pkg::ALU_SLT;
      ctrl_pkg::FNC_SLTU:    op = ctrl_pkg::ALU_SLTU;
      ctrl_pkg::FNC_XOR:     op = ctrl_pkg::ALU_XOR;
      ctrl_pkg::FNC_SRL_SRA: op = alt_fn ? ctrl_pkg::ALU_SRA : ctrl_pkg::ALU_SRL;
      ctrl_pkg::FNC_OR:      op = ctrl_pkg::ALU_OR;
      ctrl_pkg::FNC_AND:     op = ctrl_pkg::ALU_AND;
      default:               op = ctrl_pkg::ALU_ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    alu_op = ctrl_pkg::ALU_ADD;   // Bubble and no-op defaults
    a_sel  = ctrl_pkg::A_RS1;
    b_sel  = ctrl_pkg::B_RS2;
    br_un  = 1'b0;
    if (instr_valid) begin
      case (opc)
        ctrl_pkg::OPC_RTYPE: begin
          alu_op = alu_of(f3, alt);
        end
        ctrl_pkg::OPC_ITYPE: begin
          alu_op = alu_of(f3, alt && (f3 == ctrl_pkg::FNC_SRL_SRA));   // Only SRAI
          b_sel  = ctrl_pkg::B_IMM;
        end
        ctrl_pkg::OPC_LOAD, ctrl_pkg::OPC_STORE, ctrl_pkg::OPC_JALR: begin
          b_sel = ctrl_pkg::B_IMM;   // rs1 + offset
        end
        ctrl_pkg::OPC_BRANCH: begin
          a_sel = ctrl_pkg::A_PC;    // Branch target
          b_sel = ctrl_pkg::B_IMM;
          br_un = (f3 == ctrl_pkg::FNC_BLTU) || (f3 == ctrl_pkg::FNC_BGEU);
        end
        ctrl_pkg::OPC_JAL, ctrl_pkg::OPC_AUIPC: begin
          a_sel = ctrl_pkg::A_PC;
          b_sel = ctrl_pkg::B_IMM;
        end
        ctrl_pkg::OPC_LUI: begin
          a_sel = ctrl_pkg::A_ZERO;  // 0 + upper immediate
          b_sel = ctrl_pkg::B_IMM;
        end
        default: begin
          // CSR and unknown opcodes pass through as no-ops
        end
      endcase
    end
  end

  // The ALU only implements the ten listed operations
  always_comb begin
    assert #0 (!$isunknown(alu_op) && (alu_op <= ctrl_pkg::ALU_SLTU))
      else $error("exec_decoder: undefined ALU operation %0d", alu_op);
  end

endmodule

/* forward_unit.sv */
////////////////////////////////////////////////////////////////////////////
// WF-to-X forwarding. Compares the WF destination with each X source and
// selects the ALU result or the load data for the matching operand.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module forward_unit (
  input  ctrl_pkg::instr_t   instr,
  input  ctrl_pkg::wf_ctrl_t wf_ctrl,
  output ctrl_pkg::fwd_sel_t fwd_a,
  output ctrl_pkg::fwd_sel_t fwd_b
);

  ctrl_pkg::opcode_t  opc;
  logic               reads_rs1;
  logic               reads_rs2;
  logic               wf_writes;   // WF result lands in a real register
  ctrl_pkg::fwd_sel_t path;

  assign opc = ctrl_pkg::opcode_of(instr);

  assign reads_rs1 = !(opc inside {ctrl_pkg::OPC_JAL, ctrl_pkg::OPC_AUIPC, ctrl_pkg::OPC_LUI});
  assign reads_rs2 = opc inside {ctrl_pkg::OPC_RTYPE, ctrl_pkg::OPC_STORE, ctrl_pkg::OPC_BRANCH};

  // x0 is hardwired and never a forwarding source
  assign wf_writes = wf_ctrl.rf_we && (wf_ctrl.rd != '0);

  assign path = (wf_ctrl.wb_sel == ctrl_pkg::WB_MEM) ? ctrl_pkg::FWD_LOAD : ctrl_pkg::FWD_ALU;

  assign fwd_a = (reads_rs1 && wf_writes && (wf_ctrl.rd == ctrl_pkg::rs1_of(instr)))
                 ? path : ctrl_pkg::FWD_NONE;
  assign fwd_b = (reads_rs2 && wf_writes && (wf_ctrl.rd == ctrl_pkg::rs2_of(instr)))
                 ? path : ctrl_pkg::FWD_NONE;

  // A write to x0 in WF must leave both X operands on the register file
  always_comb begin
    assert #0 ((wf_ctrl.rd != '0) ||
               ((fwd_a == ctrl_pkg::FWD_NONE) && (fwd_b == ctrl_pkg::FWD_NONE)))
      else $error("forward_unit: forwarding from x0");
  end

endmodule

/* pipe_ctrl_top.sv */
////////////////////////////////////////////////////////////////////////////
// Control path of the three-stage RV32I pipeline. Connects the X-stage
// decoder, branch and forwarding units with the WF-stage controls.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module pipe_ctrl_top (
  input  logic               clk,
  input  logic               rst,
  input  ctrl_pkg::instr_t   instr,        // Instruction in X
  input  logic               instr_valid,
  input  logic               br_eq,
  input  logic               br_lt,
  output ctrl_pkg::x_ctrl_t  x_ctrl,
  output ctrl_pkg::pc_sel_t  pc_sel,
  output logic               flush,        // Squash decode
  output ctrl_pkg::wf_ctrl_t wf_ctrl
);

  ctrl_pkg::alu_op_t  alu_op;
  ctrl_pkg::a_sel_t   a_sel;
  ctrl_pkg::b_sel_t   b_sel;
  logic               br_un;
  ctrl_pkg::fwd_sel_t fwd_a;
  ctrl_pkg::fwd_sel_t fwd_b;

  exec_decoder i_exec_decoder (
    .instr       (instr),
    .instr_valid (instr_valid),
    .alu_op      (alu_op),
    .a_sel       (a_sel),
    .b_sel       (b_sel),
    .br_un       (br_un)
  );

  branch_unit i_branch_unit (
    .rst         (rst),
    .instr       (instr),
    .instr_valid (instr_valid),
    .br_eq       (br_eq),
    .br_lt       (br_lt),
    .pc_sel      (pc_sel),
    .flush       (flush)
  );

  forward_unit i_forward_unit (
    .instr   (instr),
    .wf_ctrl (wf_ctrl),
    .fwd_a   (fwd_a),
    .fwd_b   (fwd_b)
  );

  writeback_ctrl i_writeback_ctrl (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instr_valid (instr_valid),
    .wf_ctrl     (wf_ctrl)
  );

  assign x_ctrl.alu_op = alu_op;
  assign x_ctrl.a_sel  = a_sel;
  assign x_ctrl.b_sel  = b_sel;
  assign x_ctrl.br_un  = br_un;
  assign x_ctrl.fwd_a  = instr_valid ? fwd_a : ctrl_pkg::FWD_NONE;   // Bubbles never forward
  assign x_ctrl.fwd_b  = instr_valid ? fwd_b : ctrl_pkg::FWD_NONE;

endmodule

/* tb.f */
ctrl_pkg.sv
exec_decoder.sv
branch_unit.sv
forward_unit.sv
writeback_ctrl.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv

/* tb_pipe_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for pipe_ctrl_top. Runs directed decode, branch
// and forwarding sequences, then a random stream, against a reference model.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_pipe_ctrl;

  typedef struct packed {
    ctrl_pkg::instr_t instr;
    logic             valid;
    logic             br_eq;
    logic             br_lt;
  } vec_t;

  typedef struct packed {
    ctrl_pkg::x_ctrl_t  x_ctrl;
    ctrl_pkg::pc_sel_t  pc_sel;
    logic               flush;
    ctrl_pkg::wf_ctrl_t wf_ctrl;
  } ctrl_out_t;

  localparam int NUM_RANDOM = 2000;
  localparam ctrl_pkg::funct3_t BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  localparam ctrl_pkg::funct3_t LD_F3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

  logic               clk;
  logic               rst;
  ctrl_pkg::instr_t   instr;
  logic               instr_valid;
  logic               br_eq;
  logic               br_lt;
  ctrl_pkg::x_ctrl_t  x_ctrl;
  ctrl_pkg::pc_sel_t  pc_sel;
  logic               flush;
  ctrl_pkg::wf_ctrl_t wf_ctrl;

  vec_t             vectors[$];
  int               num_vectors;
  logic             vectors_ready;
  int               error_count;
  ctrl_pkg::instr_t model_wf_instr;   // Previous X instruction
  logic             model_wf_valid;

  pipe_ctrl_top i_pipe_ctrl_top (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instr_valid (instr_valid),
    .br_eq       (br_eq),
    .br_lt       (br_lt),
    .x_ctrl      (x_ctrl),
    .pc_sel      (pc_sel),
    .flush       (flush),
    .wf_ctrl     (wf_ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic ctrl_pkg::instr_t make_instr(ctrl_pkg::opcode_t opc, ctrl_pkg::funct3_t f3,
      logic b30, ctrl_pkg::reg_idx_t rd, ctrl_pkg::reg_idx_t rs1, ctrl_pkg::reg_idx_t rs2);
    return {1'b0, b30, 5'b00000, rs2, rs1, f3, rd, opc, 2'b11};
  endfunction

  // ALU table from the RV32I funct3 encodings
  function automatic ctrl_pkg::alu_op_t alu_expect(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? ctrl_pkg::ALU_SUB : ctrl_pkg::ALU_ADD;
      3'b001:  return ctrl_pkg::ALU_SLL;
      3'b010:  return ctrl_pkg::ALU_SLT;
      3'b011:  return ctrl_pkg::ALU_SLTU;
      3'b100:  return ctrl_pkg::ALU_XOR;
      3'b101:  return alt ? ctrl_pkg::ALU_SRA : ctrl_pkg::ALU_SRL;
      3'b110:  return ctrl_pkg::ALU_OR;
      default: return ctrl_pkg::ALU_AND;
    endcase
  endfunction

  function automatic ctrl_out_t ref_ctrl(logic in_rst, ctrl_pkg::instr_t x_instr, logic x_valid,
      logic eq, logic lt, ctrl_pkg::instr_t w_instr, logic w_valid);
    ctrl_out_t  e;
    logic [4:0] opc;
    logic [4:0] wopc;
    logic [2:0] f3;
    logic       taken;
    opc  = x_instr[6:2];
    f3   = x_instr[14:12];
    wopc = w_instr[6:2];
    e    = '0;
    e.x_ctrl.alu_op = ctrl_pkg::ALU_ADD;
    e.x_ctrl.a_sel  = ctrl_pkg::A_RS1;
    e.x_ctrl.b_sel  = ctrl_pkg::B_RS2;
    e.x_ctrl.fwd_a  = ctrl_pkg::FWD_NONE;
    e.x_ctrl.fwd_b  = ctrl_pkg::FWD_NONE;
    if (x_valid && (opc == ctrl_pkg::OPC_RTYPE)) begin
      e.x_ctrl.alu_op = alu_expect(f3, x_instr[30]);
    end else if (x_valid && (opc == ctrl_pkg::OPC_ITYPE)) begin
      e.x_ctrl.alu_op = alu_expect(f3, x_instr[30] && (f3 == 3'b101));   // SRAI only
      e.x_ctrl.b_sel  = ctrl_pkg::B_IMM;
    end else if (x_valid && (opc != ctrl_pkg::OPC_RTYPE)) begin
      e.x_ctrl.b_sel = ctrl_pkg::B_IMM;   // Every other legal opcode adds an immediate
      if (opc inside {ctrl_pkg::OPC_BRANCH, ctrl_pkg::OPC_JAL, ctrl_pkg::OPC_AUIPC})
        e.x_ctrl.a_sel = ctrl_pkg::A_PC;
      if (opc == ctrl_pkg::OPC_LUI)
        e.x_ctrl.a_sel = ctrl_pkg::A_ZERO;
      e.x_ctrl.br_un = (opc == ctrl_pkg::OPC_BRANCH) && (f3 inside {3'b110, 3'b111});
    end

    case (f3)
      3'b000:         taken = eq;
      3'b001:         taken = !eq;
      3'b100, 3'b110: taken = lt;
      3'b101, 3'b111: taken = !lt;
      default:        taken = 1'b0;
    endcase
    taken = taken && x_valid && (opc == ctrl_pkg::OPC_BRANCH);
    if (in_rst)
      e.pc_sel = ctrl_pkg::PC_RESET;
    else if (x_valid && (opc == ctrl_pkg::OPC_JAL))
      e.pc_sel = ctrl_pkg::PC_JAL;
    else if ((x_valid && (opc == ctrl_pkg::OPC_JALR)) || taken)
      e.pc_sel = ctrl_pkg::PC_ALU;
    else
      e.pc_sel = ctrl_pkg::PC_SEQ;
    e.flush = (e.pc_sel == ctrl_pkg::PC_JAL) || (e.pc_sel == ctrl_pkg::PC_ALU);

    e.wf_ctrl.rf_we = w_valid && !(wopc inside {ctrl_pkg::OPC_STORE, ctrl_pkg::OPC_BRANCH});
    e.wf_ctrl.rd    = w_instr[11:7];
    e.wf_ctrl.ldx   = ctrl_pkg::LDX_W;
    if (wopc == ctrl_pkg::OPC_LOAD) begin
      e.wf_ctrl.wb_sel = ctrl_pkg::WB_MEM;
      case (w_instr[14:12])
        3'b000:  e.wf_ctrl.ldx = ctrl_pkg::LDX_B;
        3'b001:  e.wf_ctrl.ldx = ctrl_pkg::LDX_H;
        3'b100:  e.wf_ctrl.ldx = ctrl_pkg::LDX_BU;
        3'b101:  e.wf_ctrl.ldx = ctrl_pkg::LDX_HU;
        default: e.wf_ctrl.ldx = ctrl_pkg::LDX_W;
      endcase
    end else if (wopc inside {ctrl_pkg::OPC_JAL, ctrl_pkg::OPC_JALR}) begin
      e.wf_ctrl.wb_sel = ctrl_pkg::WB_PC4;
    end else begin
      e.wf_ctrl.wb_sel = ctrl_pkg::WB_ALU;
    end

    if (x_valid && e.wf_ctrl.rf_we && (e.wf_ctrl.rd != 5'd0)) begin
      if (!(opc inside {ctrl_pkg::OPC_JAL, ctrl_pkg::OPC_AUIPC, ctrl_pkg::OPC_LUI}) &&
          (x_instr[19:15] == e.wf_ctrl.rd))
        e.x_ctrl.fwd_a = (wopc == ctrl_pkg::OPC_LOAD) ? ctrl_pkg::FWD_LOAD : ctrl_pkg::FWD_ALU;
      if ((opc inside {ctrl_pkg::OPC_RTYPE, ctrl_pkg::OPC_STORE, ctrl_pkg::OPC_BRANCH}) &&
          (x_instr[24:20] == e.wf_ctrl.rd))
        e.x_ctrl.fwd_b = (wopc == ctrl_pkg::OPC_LOAD) ? ctrl_pkg::FWD_LOAD : ctrl_pkg::FWD_ALU;
    end
    return e;
  endfunction

  task automatic add_vector(ctrl_pkg::instr_t vi, logic valid, logic eq, logic lt);
    vec_t v;
    v.instr = vi;
    v.valid = valid;
    v.br_eq = eq;
    v.br_lt = lt;
    vectors.push_back(v);
  endtask

  task automatic build_directed();
    for (int b = 0; b < 2; b++) begin
      for (int f = 0; f < 8; f++) begin
        add_vector(make_instr(ctrl_pkg::OPC_RTYPE, 3'(f), 1'(b), 5'd1, 5'd2, 5'd3), 1'b1, 0, 0);
        add_vector(make_instr(ctrl_pkg::OPC_ITYPE, 3'(f), 1'(b), 5'd2, 5'd3, 5'd1), 1'b1, 0, 0);
      end
    end
    foreach (LD_F3[i])
      add_vector(make_instr(ctrl_pkg::OPC_LOAD, LD_F3[i], 1'b0, 5'd3, 5'd1, 5'd0), 1'b1, 0, 0);
    foreach (BR_F3[i]) begin
      for (int c = 0; c < 4; c++)   // All br_eq and br_lt pairs
        add_vector(make_instr(ctrl_pkg::OPC_BRANCH, BR_F3[i], 1'b0, 5'd0, 5'd1, 5'd2),
                   1'b1, c[1], c[0]);
    end
    add_vector(make_instr(ctrl_pkg::OPC_JAL, 3'b000, 1'b0, 5'd1, 5'd0, 5'd0), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_JALR, 3'b000, 1'b0, 5'd1, 5'd2, 5'd0), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_AUIPC, 3'b000, 1'b0, 5'd2, 5'd0, 5'd0), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_LUI, 3'b000, 1'b0, 5'd3, 5'd0, 5'd0), 1'b1, 0, 0);
    // Dependent pairs with ALU, load, x0, store and bubble producers
    add_vector(make_instr(ctrl_pkg::OPC_RTYPE, 3'b000, 1'b0, 5'd1, 5'd2, 5'd3), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_RTYPE, 3'b111, 1'b0, 5'd2, 5'd1, 5'd1), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_LOAD, 3'b010, 1'b0, 5'd1, 5'd2, 5'd0), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_STORE, 3'b010, 1'b0, 5'd0, 5'd1, 5'd1), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_ITYPE, 3'b000, 1'b0, 5'd0, 5'd1, 5'd0), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_RTYPE, 3'b000, 1'b0, 5'd1, 5'd0, 5'd0), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_STORE, 3'b000, 1'b0, 5'd1, 5'd2, 5'd3), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_BRANCH, 3'b000, 1'b0, 5'd0, 5'd1, 5'd1), 1'b1, 1, 0);
    add_vector(make_instr(ctrl_pkg::OPC_ITYPE, 3'b000, 1'b0, 5'd2, 5'd0, 5'd0), 1'b0, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_RTYPE, 3'b000, 1'b0, 5'd3, 5'd2, 5'd2), 1'b1, 0, 0);
    add_vector(make_instr(ctrl_pkg::OPC_RTYPE, 3'b100, 1'b0, 5'd1, 5'd2, 5'd3), 1'b1, 0, 0);
  endtask

  task automatic build_random(int count);
    int unsigned       r;
    ctrl_pkg::opcode_t opc;
    ctrl_pkg::funct3_t f3;
    for (int n = 0; n < count; n++) begin
      r = $urandom;
      case (r % 9)
        0:       opc = ctrl_pkg::OPC_RTYPE;
        1:       opc = ctrl_pkg::OPC_ITYPE;
        2:       opc = ctrl_pkg::OPC_LOAD;
        3:       opc = ctrl_pkg::OPC_STORE;
        4:       opc = ctrl_pkg::OPC_BRANCH;
        5:       opc = ctrl_pkg::OPC_JAL;
        6:       opc = ctrl_pkg::OPC_JALR;
        7:       opc = ctrl_pkg::OPC_AUIPC;
        default: opc = ctrl_pkg::OPC_LUI;
      endcase
      r = $urandom;
      if (opc == ctrl_pkg::OPC_BRANCH)      f3 = BR_F3[r % 6];
      else if (opc == ctrl_pkg::OPC_LOAD)   f3 = LD_F3[r % 5];
      else if (opc == ctrl_pkg::OPC_STORE)  f3 = 3'(r % 3);
      else if (opc == ctrl_pkg::OPC_JALR)   f3 = 3'b000;
      else                                  f3 = 3'(r);
      r = $urandom;
      add_vector(make_instr(opc, f3, r[0], {3'b000, r[2:1]}, {3'b000, r[4:3]}, {3'b000, r[6:5]}),
                 r[8:7] != 2'b00, r[9], r[10]);   // Registers x0..x3, mostly valid
    end
  endtask

  task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      error_count++;
      $display("[ERROR] t=%0t %s: got %0h expected %0h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_outputs();
    ctrl_out_t e;
    e = ref_ctrl(rst, instr, instr_valid, br_eq, br_lt, model_wf_instr, model_wf_valid);
    check_field("x_ctrl.alu_op", 32'(x_ctrl.alu_op), 32'(e.x_ctrl.alu_op));
    check_field("x_ctrl.a_sel", 32'(x_ctrl.a_sel), 32'(e.x_ctrl.a_sel));
    check_field("x_ctrl.b_sel", 32'(x_ctrl.b_sel), 32'(e.x_ctrl.b_sel));
    check_field("x_ctrl.br_un", 32'(x_ctrl.br_un), 32'(e.x_ctrl.br_un));
    check_field("x_ctrl.fwd_a", 32'(x_ctrl.fwd_a), 32'(e.x_ctrl.fwd_a));
    check_field("x_ctrl.fwd_b", 32'(x_ctrl.fwd_b), 32'(e.x_ctrl.fwd_b));
    check_field("pc_sel", 32'(pc_sel), 32'(e.pc_sel));
    check_field("flush", 32'(flush), 32'(e.flush));
    check_field("wf_ctrl.rf_we", 32'(wf_ctrl.rf_we), 32'(e.wf_ctrl.rf_we));
    check_field("wf_ctrl.wb_sel", 32'(wf_ctrl.wb_sel), 32'(e.wf_ctrl.wb_sel));
    check_field("wf_ctrl.ldx", 32'(wf_ctrl.ldx), 32'(e.wf_ctrl.ldx));
    check_field("wf_ctrl.rd", 32'(wf_ctrl.rd), 32'(e.wf_ctrl.rd));
  endtask

  always @(posedge clk) begin
    model_wf_valid <= rst ? 1'b0 : instr_valid;
    model_wf_instr <= instr;
  end

  // Compare 1 ns before each rising edge
  initial begin
    forever begin
      @(posedge clk);
      #9;
      check_outputs();
    end
  end

  initial begin
    wait (vectors_ready);
    #((num_vectors + 20) * 10);
    $display("Timeout: the stimulus did not finish in the expected time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst           = 1'b1;
    instr         = make_instr(ctrl_pkg::OPC_JAL, 3'b000, 1'b0, 5'd1, 5'd0, 5'd0);
    instr_valid   = 1'b1;   // A jump in X while reset holds
    br_eq         = 1'b0;
    br_lt         = 1'b0;
    error_count   = 0;
    vectors_ready = 1'b0;
    void'($urandom(6));
    build_directed();
    build_random(NUM_RANDOM);
    num_vectors   = vectors.size();
    vectors_ready = 1'b1;
    repeat (2) @(posedge clk);   // Two reset cycles
    foreach (vectors[i]) begin
      @(negedge clk);
      rst         = 1'b0;
      instr       = vectors[i].instr;
      instr_valid = vectors[i].valid;
      br_eq       = vectors[i].br_eq;
      br_lt       = vectors[i].br_lt;
    end
    repeat (2) @(negedge clk);   // Let the last WF check run
    #5;
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* writeback_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// WF stage. Captures the X instruction every cycle and decodes register
// write enable, writeback source, load extension and destination.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module writeback_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  ctrl_pkg::instr_t   instr,
  input  logic               instr_valid,
  output ctrl_pkg::wf_ctrl_t wf_ctrl
);

  ctrl_pkg::instr_t  wf_instr;   // Instruction now in WF
  logic              wf_valid;
  ctrl_pkg::opcode_t opc;

  always_ff @(posedge clk) begin
    if (rst) begin
      wf_valid <= 1'b0;
    end else begin
      wf_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    wf_instr <= instr;
  end

  assign opc = ctrl_pkg::opcode_of(wf_instr);

  always_comb begin
    wf_ctrl.rf_we = wf_valid && ctrl_pkg::writes_rd(opc);
    wf_ctrl.rd    = ctrl_pkg::rd_of(wf_instr);
    wf_ctrl.ldx   = ctrl_pkg::LDX_W;

    case (opc)
      ctrl_pkg::OPC_LOAD:                   wf_ctrl.wb_sel = ctrl_pkg::WB_MEM;
      ctrl_pkg::OPC_JAL, ctrl_pkg::OPC_JALR: wf_ctrl.wb_sel = ctrl_pkg::WB_PC4;   // Link
      default:                              wf_ctrl.wb_sel = ctrl_pkg::WB_ALU;
    endcase

    if (opc == ctrl_pkg::OPC_LOAD) begin
      case (ctrl_pkg::funct3_of(wf_instr))
        ctrl_pkg::FNC_LB:  wf_ctrl.ldx = ctrl_pkg::LDX_B;
        ctrl_pkg::FNC_LH:  wf_ctrl.ldx = ctrl_pkg::LDX_H;
        ctrl_pkg::FNC_LBU: wf_ctrl.ldx = ctrl_pkg::LDX_BU;
        ctrl_pkg::FNC_LHU: wf_ctrl.ldx = ctrl_pkg::LDX_HU;
        default:           wf_ctrl.ldx = ctrl_pkg::LDX_W;   // LW and reserved widths
      endcase
    end
  end

  // A bubble in X must reach WF without touching the register file
  a_bubble_no_write: assert property (
    @(posedge clk) disable iff (rst) !instr_valid |=> !wf_ctrl.rf_we
  ) else $error("writeback_ctrl: register write from an invalid instruction");

endmodule
